//--- logic/dmem_pkg.sv
package dmem_pkg;

    localparam int ADDR_BITS = 10;                       // 1 KiB data RAM
    localparam int SET_BITS  = 3;                        // 8 lines
    localparam int TAG_BITS  = ADDR_BITS - SET_BITS - 2;
    localparam int STAT_BITS = 16;
    localparam int SETS      = 1 << SET_BITS;
    localparam int RAM_BYTES = 1 << ADDR_BITS;

    // funct3 encodings, shared by loads and stores
    localparam logic [2:0] F3_LW  = 3'd0;
    localparam logic [2:0] F3_LH  = 3'd1;
    localparam logic [2:0] F3_LB  = 3'd2;
    localparam logic [2:0] F3_LHU = 3'd5;
    localparam logic [2:0] F3_LBU = 3'd6;

    typedef struct packed {
        logic        rd;                                 // load strobe
        logic        wr;                                 // store strobe
        logic [2:0]  funct3;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_req_t;

    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [31-ADDR_BITS:0] unused;               // above the RAM size
            logic [TAG_BITS-1:0]   tag;
            logic [SET_BITS-1:0]   set;
            logic [1:0]            offset;
        } f;
    } addr_u;

    typedef struct packed {
        logic [STAT_BITS-1:0] hits;
        logic [STAT_BITS-1:0] misses;
        logic [STAT_BITS-1:0] bypass;
    } dmem_stats_t;

    // raw holds the bytes read little-endian from the access address
    function automatic logic [31:0] load_format(input logic [31:0] raw,
                                                input logic [2:0]  funct3);
        case (funct3)
            F3_LH:   return {{16{raw[15]}}, raw[15:0]};
            F3_LB:   return {{24{raw[7]}}, raw[7:0]};
            F3_LHU:  return {16'h0000, raw[15:0]};
            F3_LBU:  return {24'h000000, raw[7:0]};
            default: return raw;                         // LW and unknown codes
        endcase
    endfunction

    function automatic logic [2:0] access_bytes(input logic [2:0] funct3);
        case (funct3)
            F3_LH, F3_LHU: return 3'd2;
            F3_LB, F3_LBU: return 3'd1;
            default:       return 3'd4;
        endcase
    endfunction

endpackage

//--- logic/data_ram.sv
module data_ram
    import dmem_pkg::*;
(
    input  logic        clk,
    input  mem_req_t    req,
    output logic [31:0] ram_word
);

    logic [7:0]           mem [RAM_BYTES];
    logic [ADDR_BITS-1:0] byte_addr [4];             // four consecutive bytes
    logic [2:0]           nbytes;

    // address arithmetic is ADDR_BITS wide so it wraps at the top
    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            byte_addr[i] = req.addr[ADDR_BITS-1:0] + ADDR_BITS'(i);
        end
    end

    assign nbytes = access_bytes(req.funct3);

    // little-endian read, lowest address in the low byte
    assign ram_word = {mem[byte_addr[3]], mem[byte_addr[2]],
                       mem[byte_addr[1]], mem[byte_addr[0]]};

    always_ff @(posedge clk)
    begin
        if (req.wr)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (3'(i) < nbytes)
                begin
                    mem[byte_addr[i]] <= req.wdata[8*i +: 8];  // low byte first
                end
            end
        end
    end

    // contents start at zero, no reset
    initial
    begin
        for (int i = 0; i < RAM_BYTES; i++)
        begin
            mem[i] = 8'h00;
        end
    end

endmodule

//--- logic/dcache.sv
module dcache
    import dmem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  mem_req_t    req,
    input  logic        cache_en,
    input  logic [31:0] ram_word,
    output logic [31:0] rdata,
    output logic        hit,
    output logic        ld_hit,
    output logic        ld_miss,
    output logic        ld_bypass
);

    logic [31:0]         line_data [SETS];
    logic [TAG_BITS-1:0] line_tag  [SETS];
    logic [SETS-1:0]     line_valid;

    addr_u       cur;                                // access address
    addr_u       nxt;                                // following word
    logic        cur_match;
    logic        nxt_match;
    logic        cacheable;
    logic [2:0]  nbytes;
    logic [3:0]  base_mask;
    logic [7:0]  span_mask;                          // bytes touched, two words
    logic        spans;
    logic        full_word;
    logic        store;
    logic [31:0] bit_mask;
    logic [31:0] wdata_sh;
    logic [31:0] merged;

    assign cur.raw = req.addr;
    assign nxt.raw = {req.addr[31:2] + 30'd1, 2'b00};

    assign cur_match = line_valid[cur.f.set] && (line_tag[cur.f.set] == cur.f.tag);
    assign nxt_match = line_valid[nxt.f.set] && (line_tag[nxt.f.set] == nxt.f.tag);

    // only word-aligned loads go through the cache
    assign cacheable = req.rd && cache_en && (cur.f.offset == 2'b00);

    assign hit       = cacheable && cur_match;
    assign ld_hit    = hit;
    assign ld_miss   = cacheable && !cur_match;
    assign ld_bypass = req.rd && !cacheable;

    assign rdata = load_format(hit ? line_data[cur.f.set] : ram_word, req.funct3);

    assign nbytes = access_bytes(req.funct3);
    assign store  = req.wr && cache_en;

    always_comb
    begin
        case (nbytes)
            3'd4:    base_mask = 4'b1111;
            3'd2:    base_mask = 4'b0011;
            default: base_mask = 4'b0001;
        endcase
        span_mask = {4'b0000, base_mask} << cur.f.offset;
        for (int b = 0; b < 4; b++)
        begin
            bit_mask[8*b +: 8] = {8{span_mask[b]}};
        end
        wdata_sh = req.wdata << {cur.f.offset, 3'b000};
        merged   = (line_data[cur.f.set] & ~bit_mask) | (wdata_sh & bit_mask);
    end

    assign spans     = |span_mask[7:4];              // store runs into next word
    assign full_word = (span_mask == 8'h0f);         // word store at offset zero

    // line payload and tags
    always_ff @(posedge clk)
    begin
        if (ld_miss)
        begin
            line_data[cur.f.set] <= ram_word;        // raw word, not the formatted one
            line_tag[cur.f.set]  <= cur.f.tag;
        end
        else if (store)
        begin
            if (full_word)
            begin
                line_data[cur.f.set] <= req.wdata;
                line_tag[cur.f.set]  <= cur.f.tag;
            end
            else if (!spans && cur_match)
            begin
                line_data[cur.f.set] <= merged;
            end
        end
    end

    // valid bits
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            line_valid <= '0;
        end
        else if (ld_miss)
        begin
            line_valid[cur.f.set] <= 1'b1;
        end
        else if (store)
        begin
            if (full_word)
            begin
                line_valid[cur.f.set] <= 1'b1;       // allocate
            end
            else if (spans)
            begin
                // both overlapped words go, each checked against its own tag
                if (cur_match)
                begin
                    line_valid[cur.f.set] <= 1'b0;
                end
                if (nxt_match)
                begin
                    line_valid[nxt.f.set] <= 1'b0;
                end
            end
        end
    end

endmodule

//--- logic/cache_stats.sv
module cache_stats
    import dmem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ld_hit,
    input  logic        ld_miss,
    input  logic        ld_bypass,
    output dmem_stats_t stats
);

    // counters wrap silently
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            stats <= '0;
        end
        else
        begin
            if (ld_hit)
            begin
                stats.hits <= stats.hits + 1'b1;
            end
            if (ld_miss)
            begin
                stats.misses <= stats.misses + 1'b1;
            end
            if (ld_bypass)
            begin
                stats.bypass <= stats.bypass + 1'b1;  // unaligned or cache off
            end
        end
    end

endmodule

//--- logic/dmem_top.sv
module dmem_top
    import dmem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  mem_req_t    req,
    input  logic        cache_en,
    output logic [31:0] rdata,
    output logic        hit,
    output dmem_stats_t stats
);

    logic [31:0] ram_word;                           // raw bytes at req.addr
    logic        ld_hit;
    logic        ld_miss;
    logic        ld_bypass;

    data_ram u_data_ram (
        .clk      (clk),
        .req      (req),
        .ram_word (ram_word)
    );

    dcache u_dcache (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .cache_en  (cache_en),
        .ram_word  (ram_word),
        .rdata     (rdata),
        .hit       (hit),
        .ld_hit    (ld_hit),
        .ld_miss   (ld_miss),
        .ld_bypass (ld_bypass)
    );

    cache_stats u_cache_stats (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_hit    (ld_hit),
        .ld_miss   (ld_miss),
        .ld_bypass (ld_bypass),
        .stats     (stats)
    );

endmodule

//--- verif/dmem_checker.sv
module dmem_checker
    import dmem_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input mem_req_t req,
    input logic     cache_en,
    input logic     hit,
    input logic     ld_hit,
    input logic     ld_miss,
    input logic     ld_bypass
);

    int fail_count = 0;                             // read by the testbench top

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(req.rd && req.wr))
        else begin $error("load and store strobes high together"); fail_count++; end

    a_one_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({ld_hit, ld_miss, ld_bypass}))
        else begin $error("more than one load pulse in a cycle"); fail_count++; end

    a_hit_cacheable: assert property (@(posedge clk) disable iff (!rst_n)
        hit |-> (req.rd && cache_en && req.addr[1:0] == 2'b00))
        else begin $error("hit on a load that is not cacheable"); fail_count++; end

    // first cycle out of reset stays quiet
    a_quiet_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> !(ld_hit || ld_miss || ld_bypass))
        else begin $error("load pulse in the first cycle after reset"); fail_count++; end

endmodule

bind dcache dmem_checker u_dmem_checker (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .cache_en  (cache_en),
    .hit       (hit),
    .ld_hit    (ld_hit),
    .ld_miss   (ld_miss),
    .ld_bypass (ld_bypass)
);

//--- verif/dmem_scoreboard.sv
module dmem_scoreboard
    import dmem_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  mem_req_t    req,
    input  logic        cache_en,
    input  logic [31:0] rdata,
    input  logic        hit,
    input  dmem_stats_t stats,
    input  int          test_id,
    input  logic        test_end,
    output int          errors,
    output int          checks
);

    logic [7:0]          ram_m  [RAM_BYTES];        // byte image of the RAM
    logic [31:0]         c_data [SETS];
    logic [TAG_BITS-1:0] c_tag  [SETS];
    logic [SETS-1:0]     c_valid;
    dmem_stats_t         exp_stats;
    logic                exp_hit;
    logic [31:0]         exp_data;
    logic [SET_BITS-1:0] ld_set;
    int                  err_cnt = 0;
    int                  chk_cnt = 0;
    int                  err_mark = 0;
    int                  chk_mark = 0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    initial
    begin
        for (int i = 0; i < RAM_BYTES; i++)
        begin
            ram_m[i] = 8'h00;
        end
    end

    function automatic string test_name(input int id);
        case (id)
            1:       return "cold misses then hits";
            2:       return "load formats";
            3:       return "set conflict";
            4:       return "unaligned stores";
            5:       return "cache disabled";
            6:       return "random mix";
            default: return "unknown";
        endcase
    endfunction

    function automatic int width_of(input logic [2:0] f3);
        if (f3 == F3_LB || f3 == F3_LBU)
            return 1;
        if (f3 == F3_LH || f3 == F3_LHU)
            return 2;
        return 4;                                   // word and unknown codes
    endfunction

    // four bytes from the model RAM, low address in the low byte
    function automatic logic [31:0] bytes_at(input logic [31:0] a);
        logic [ADDR_BITS-1:0] p;
        logic [31:0]          w;
        p = a[ADDR_BITS-1:0];
        for (int i = 0; i < 4; i++)
        begin
            w[8*i +: 8] = ram_m[p + ADDR_BITS'(i)];
        end
        return w;
    endfunction

    function automatic logic [31:0] extend(input logic [31:0] w, input logic [2:0] f3);
        logic [31:0] v;
        v = w;
        if (width_of(f3) == 2)
            v = (f3 == F3_LH && w[15]) ? {16'hffff, w[15:0]} : {16'h0000, w[15:0]};
        else if (width_of(f3) == 1)
            v = (f3 == F3_LB && w[7]) ? {24'hffffff, w[7:0]} : {24'h000000, w[7:0]};
        return v;
    endfunction

    // reference result of a load against the current model state
    function automatic void predict_load(input logic [31:0] addr, input logic [2:0] f3,
                                         input logic en, output logic p_hit,
                                         output logic [31:0] p_data);
        logic [SET_BITS-1:0] s;
        logic                present;
        s       = addr[SET_BITS+1:2];
        present = c_valid[s] && (c_tag[s] == addr[ADDR_BITS-1:SET_BITS+2]);
        p_hit   = en && (addr[1:0] == 2'b00) && present;
        p_data  = extend(p_hit ? c_data[s] : bytes_at(addr), f3);
    endfunction

    task automatic model_store(input logic [31:0] addr, input logic [2:0] f3,
                               input logic [31:0] wd, input logic en);
        int                   n;
        int                   off;
        logic [ADDR_BITS-1:0] nw;
        logic [SET_BITS-1:0]  s0;
        logic [SET_BITS-1:0]  s1;
        logic                 m0;
        logic                 m1;
        n   = width_of(f3);
        off = int'(addr[1:0]);
        nw  = {addr[ADDR_BITS-1:2], 2'b00} + ADDR_BITS'(4);  // next word, wraps
        s0  = addr[SET_BITS+1:2];
        s1  = nw[SET_BITS+1:2];
        m0  = c_valid[s0] && (c_tag[s0] == addr[ADDR_BITS-1:SET_BITS+2]);
        m1  = c_valid[s1] && (c_tag[s1] == nw[ADDR_BITS-1:SET_BITS+2]);
        if (en)
        begin
            if (n == 4 && off == 0)
            begin
                c_data[s0]  = wd;                   // allocate
                c_tag[s0]   = addr[ADDR_BITS-1:SET_BITS+2];
                c_valid[s0] = 1'b1;
            end
            else if (off + n <= 4)
            begin
                for (int i = 0; i < n; i++)
                begin
                    if (m0)
                        c_data[s0][8*(off+i) +: 8] = wd[8*i +: 8];
                end
            end
            else
            begin
                if (m0)
                    c_valid[s0] = 1'b0;
                if (m1)
                    c_valid[s1] = 1'b0;
            end
        end
        for (int i = 0; i < n; i++)
        begin
            ram_m[addr[ADDR_BITS-1:0] + ADDR_BITS'(i)] = wd[8*i +: 8];
        end
    endtask

    task automatic check_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        chk_cnt++;
        if (got !== exp)
        begin
            err_cnt++;
            $display("MISMATCH %s: got 0x%h, expected 0x%h (addr 0x%h, funct3 %0d)",
                     name, got, exp, req.addr, req.funct3);
        end
    endtask

    // compare before the edge takes effect, then advance the model
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            c_valid   = '0;
            exp_stats = '0;
        end
        else
        begin
            check_field("stats.hits", 32'(stats.hits), 32'(exp_stats.hits));
            check_field("stats.misses", 32'(stats.misses), 32'(exp_stats.misses));
            check_field("stats.bypass", 32'(stats.bypass), 32'(exp_stats.bypass));
            if (req.rd)
            begin
                predict_load(req.addr, req.funct3, cache_en, exp_hit, exp_data);
                check_field("rdata", rdata, exp_data);
                check_field("hit", 32'(hit), 32'(exp_hit));
                ld_set = req.addr[SET_BITS+1:2];
                if (!cache_en || req.addr[1:0] != 2'b00)
                    exp_stats.bypass = exp_stats.bypass + STAT_BITS'(1);
                else if (exp_hit)
                    exp_stats.hits = exp_stats.hits + STAT_BITS'(1);
                else
                begin
                    exp_stats.misses = exp_stats.misses + STAT_BITS'(1);
                    c_data[ld_set]   = bytes_at(req.addr);  // raw word fill
                    c_tag[ld_set]    = req.addr[ADDR_BITS-1:SET_BITS+2];
                    c_valid[ld_set]  = 1'b1;
                end
            end
            else
            begin
                check_field("hit", 32'(hit), 32'h0);
            end
            if (req.wr)
                model_store(req.addr, req.funct3, req.wdata, cache_en);
            if (test_end)
            begin
                $display("test %0d %s: %s, %0d checks, %0d errors", test_id,
                         test_name(test_id), (err_cnt == err_mark) ? "ok" : "failed",
                         chk_cnt - chk_mark, err_cnt - err_mark);
                err_mark = err_cnt;
                chk_mark = chk_cnt;
            end
        end
    end

endmodule

//--- verif/tb_dmem.sv
module tb_dmem
    import dmem_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int TEST_CYCLES  = 17 + 13 + 19 + 24 + 15 + 401;  // ops plus one marker each
    localparam int CYCLE_LIMIT  = RESET_CYCLES + TEST_CYCLES + 50;

    logic        clk;
    logic        rst_n;
    mem_req_t    req;
    logic        cache_en;
    logic [31:0] rdata;
    logic        hit;
    dmem_stats_t stats;
    int          test_id;
    logic        test_end;
    int          sb_errors;
    int          sb_checks;
    int          assert_fails;
    int          cycle_cnt = 0;
    int          seed = 66266;

    logic [2:0] load_codes  [6] = '{F3_LW, F3_LH, F3_LB, F3_LHU, F3_LBU, 3'd7};
    logic [2:0] store_codes [4] = '{F3_LW, F3_LH, F3_LB, 3'd4};  // 4 acts as a word

    dmem_top u_dmem_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .cache_en (cache_en),
        .rdata    (rdata),
        .hit      (hit),
        .stats    (stats)
    );

    dmem_scoreboard u_scoreboard (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req),
        .cache_en (cache_en),
        .rdata    (rdata),
        .hit      (hit),
        .stats    (stats),
        .test_id  (test_id),
        .test_end (test_end),
        .errors   (sb_errors),
        .checks   (sb_checks)
    );

    assign assert_fails = u_dmem_top.u_dcache.u_dmem_checker.fail_count;

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // one request per cycle, applied on the falling edge
    task automatic drive_req(input logic rd, input logic wr, input logic [2:0] f3,
                             input logic [31:0] addr, input logic [31:0] wdata);
        @(negedge clk);
        test_end   = 1'b0;
        req.rd     = rd;
        req.wr     = wr;
        req.funct3 = f3;
        req.addr   = addr;
        req.wdata  = wdata;
    endtask

    task automatic read_mem(input logic [2:0] f3, input logic [31:0] addr);
        drive_req(1'b1, 1'b0, f3, addr, 32'h0);
    endtask

    task automatic write_mem(input logic [2:0] f3, input logic [31:0] addr,
                             input logic [31:0] wdata);
        drive_req(1'b0, 1'b1, f3, addr, wdata);
    endtask

    task automatic enable_cache(input logic en);
        @(negedge clk);
        test_end = 1'b0;
        req      = '0;
        cache_en = en;
    endtask

    task automatic close_test(input int n);
        @(negedge clk);
        req      = '0;                              // idle marker cycle
        test_id  = n;
        test_end = 1'b1;
    endtask

    task automatic run_random(input int count);
        logic [31:0] r;
        logic [31:0] upper;
        logic [31:0] addr;
        logic [5:0]  off;
        logic [2:0]  code_idx;
        for (int i = 0; i < count; i++)
        begin
            r        = $random(seed);
            upper    = $random(seed);
            off      = r[7:2];
            code_idx = r[10:8] % 3'd6;
            if (r[1])
            begin
                off[1:0] = 2'b00;                   // about half aligned
            end
            addr = {upper[31:10], 4'b1110, off};    // window 0x380..0x3bf
            if (r[0])
            begin
                read_mem(load_codes[code_idx], addr);
            end
            else
            begin
                write_mem(store_codes[r[12:11]], addr, $random(seed));
            end
        end
    endtask

    initial
    begin
        logic [31:0] vals [2];
        int          total;
        vals     = '{32'h8001_8071, 32'h1234_56f8};  // bit 15 and bit 7 differ
        clk      = 1'b0;
        rst_n    = 1'b0;
        req      = '0;
        cache_en = 1'b1;
        test_id  = 0;
        test_end = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        drive_req(1'b0, 1'b0, F3_LW, 32'h0, 32'h0);  // quiet first cycle

        for (int s = 0; s < SETS; s++)
        begin
            read_mem(F3_LW, 32'h100 + 32'(4 * s));
            read_mem(F3_LW, 32'h8000_0100 + 32'(4 * s));  // upper bits ignored
        end
        close_test(1);

        for (int v = 0; v < 2; v++)
        begin
            write_mem(F3_LW, 32'h040 + 32'(4 * v), vals[v]);
            read_mem(F3_LW, 32'h040 + 32'(4 * v));
            read_mem(F3_LH, 32'h040 + 32'(4 * v));
            read_mem(F3_LB, 32'h040 + 32'(4 * v));
            read_mem(F3_LHU, 32'h040 + 32'(4 * v));
            read_mem(F3_LBU, 32'h040 + 32'(4 * v));
        end
        close_test(2);

        write_mem(F3_LW, 32'h208, 32'hdead_beef);
        write_mem(F3_LW, 32'h228, 32'h0bad_cafe);   // same set, evicts 0x208
        for (int k = 0; k < 4; k++)
        begin
            read_mem(F3_LW, 32'h208);
            read_mem(F3_LW, 32'h208);
            read_mem(F3_LW, 32'h228);
            read_mem(F3_LW, 32'h228);
        end
        close_test(3);

        write_mem(F3_LW, 32'h300, 32'h1111_1111);
        write_mem(F3_LW, 32'h304, 32'h2222_2222);
        read_mem(F3_LW, 32'h300);
        read_mem(F3_LW, 32'h304);
        write_mem(F3_LW, 32'h302, 32'haabb_ccdd);   // spans two cached words
        read_mem(F3_LW, 32'h300);
        read_mem(F3_LW, 32'h304);
        write_mem(F3_LH, 32'h301, 32'h0000_5566);   // merge inside one word
        read_mem(F3_LW, 32'h300);
        write_mem(F3_LH, 32'h307, 32'h0000_7788);
        read_mem(F3_LW, 32'h304);
        read_mem(F3_LW, 32'h308);
        write_mem(F3_LB, 32'h303, 32'h0000_0099);
        read_mem(F3_LW, 32'h300);
        read_mem(F3_LW, 32'h301);
        read_mem(F3_LH, 32'h303);
        read_mem(F3_LB, 32'h305);
        read_mem(F3_LBU, 32'h306);
        read_mem(F3_LHU, 32'h302);
        read_mem(F3_LW, 32'h000);
        write_mem(F3_LW, 32'h3fe, 32'h4433_2211);   // wraps to address 0
        read_mem(F3_LW, 32'h000);
        read_mem(F3_LW, 32'h3fc);
        close_test(4);

        enable_cache(1'b0);
        write_mem(F3_LW, 32'h3c0, 32'hcafe_f00d);
        read_mem(F3_LW, 32'h3c0);
        read_mem(F3_LH, 32'h3c2);
        write_mem(F3_LB, 32'h3c1, 32'h0000_005a);
        read_mem(F3_LW, 32'h3c0);
        read_mem(F3_LBU, 32'h3c1);
        write_mem(F3_LW, 32'h3c4, 32'h0f0f_8080);
        read_mem(F3_LW, 32'h3c4);
        enable_cache(1'b1);
        read_mem(F3_LW, 32'h3c0);
        read_mem(F3_LW, 32'h3c0);
        read_mem(F3_LW, 32'h3c4);
        read_mem(F3_LW, 32'h3c4);
        close_test(5);

        run_random(400);
        close_test(6);

        enable_cache(1'b1);
        @(negedge clk);
        total = sb_errors + assert_fails;
        $display("checks %0d, mismatches %0d, assertion failures %0d",
                 sb_checks, sb_errors, assert_fails);
        if (total == 0)
        begin
            $display("RESULT: PASS");
        end
        else
        begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- all.f
logic/dmem_pkg.sv
logic/data_ram.sv
logic/dcache.sv
logic/cache_stats.sv
logic/dmem_top.sv
verif/dmem_checker.sv
verif/dmem_scoreboard.sv
verif/tb_dmem.sv

//--- run.sh
#!/bin/sh
# compile and run the data-memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_dmem -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dmem +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "RESULT: FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
